// File: design/br_local_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defines.svh"

module br_local_port #(
    parameter int unsigned PE_ADDR_X = 0,
    parameter int unsigned PE_ADDR_Y = 0,
    parameter int unsigned N_PE_X    = 2
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // Delivery from the broadcast router
    input  wire logic                   dlv_req_i,
    input  pe_br_pkg::br_flit_t         dlv_flit_i,
    output logic                        dlv_ack_o,

    // Monitoring channel
    output logic                        mon_req_o,
    output pe_br_pkg::br_mon_t          mon_o,
    input  wire logic                   mon_ack_i,

    // Service channel
    output logic                        svc_req_o,
    output pe_br_pkg::br_svc_flit_t     svc_o,
    input  wire logic                   svc_ack_i,

    // Local sender
    input  wire logic                   snd_req_i,
    input  pe_br_pkg::br_out_t          snd_flit_i,
    output logic                        snd_ack_o,

    // Injection into the broadcast router
    output logic                        br_req_o,
    output pe_br_pkg::br_flit_t         br_flit_o,
    input  wire logic                   br_ack_i
);

    import pe_br_pkg::*;

    // Row-major position in the mesh
    localparam logic [`BR_ADDR_W-1:0] SEQ_ADDR = `BR_ADDR_W'(PE_ADDR_Y * N_PE_X + PE_ADDR_X);

    logic                   is_mon;
    logic [`BR_ID_W-1:0]    id_q;

    ////////////////////////////////////////////////////////////////////////////
    // Delivery split
    ////////////////////////////////////////////////////////////////////////////

    assign is_mon = (dlv_flit_i.service == BR_SVC_MON);

    assign mon_req_o        = dlv_req_i && is_mon;
    assign mon_o.payload    = dlv_flit_i.payload;
    assign mon_o.seq_source = dlv_flit_i.seq_source;
    assign mon_o.producer   = dlv_flit_i.producer;
    assign mon_o.msvc       = dlv_flit_i.ksvc[`BR_MSVC_W-1:0];

    assign svc_req_o        = dlv_req_i && !is_mon;
    assign svc_o.payload    = dlv_flit_i.payload;
    assign svc_o.seq_source = dlv_flit_i.seq_source;
    assign svc_o.producer   = dlv_flit_i.producer;
    assign svc_o.ksvc       = dlv_flit_i.ksvc;

    // Ack comes from whichever channel got the flit
    assign dlv_ack_o = is_mon ? mon_ack_i : svc_ack_i;

    ////////////////////////////////////////////////////////////////////////////
    // Send side stamping
    ////////////////////////////////////////////////////////////////////////////

    // Rolling id, wraps naturally
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_q <= '0;
        end else if (br_ack_i) begin
            id_q <= id_q + 1'b1;
        end
    end

    assign br_req_o             = snd_req_i;
    assign snd_ack_o            = br_ack_i;
    assign br_flit_o.service    = snd_flit_i.service;
    assign br_flit_o.ksvc       = snd_flit_i.ksvc;
    assign br_flit_o.producer   = snd_flit_i.producer;
    assign br_flit_o.seq_source = SEQ_ADDR;
    assign br_flit_o.seq_target = snd_flit_i.seq_target;
    assign br_flit_o.id         = id_q;
    assign br_flit_o.payload    = snd_flit_i.payload;

    // Router must hold the flit until the consumer acks
    a_dlv_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (dlv_req_i && !dlv_ack_o) |=> (dlv_req_i && $stable(dlv_flit_i))
    ) else $error("delivered flit changed before ack");

endmodule

`default_nettype wire

// File: design/pe_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defines.svh"

module pe_addr_decode (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // CPU side
    input  pe_bus_pkg::cpu_req_t        cpu_req_i,
    output logic [`PE_XLEN-1:0]         cpu_rdata_o,

    // External data memory
    output pe_bus_pkg::mem_req_t        mem_req_o,
    input  wire logic [`PE_XLEN-1:0]    mem_rdata_i,

    // Peripheral strobes and read data
    output logic                        rtc_en_o,
    output logic                        plic_en_o,
    input  wire logic [`PE_XLEN-1:0]    rtc_rdata_i,
    input  wire logic [`PE_XLEN-1:0]    plic_rdata_i
);

    import pe_bus_pkg::*;

    logic [7:0]     region;
    periph_sel_t    sel_d;
    periph_sel_t    sel_q;

    assign region = cpu_req_i.addr[`PE_XLEN-1 -: 8];

    // Unmapped regions select nothing
    always_comb begin
        sel_d = SEL_NONE;
        if (cpu_req_i.en) begin
            case (region)
                `PE_REGION_DATA: sel_d = SEL_DATA;
                `PE_REGION_RTC:  sel_d = SEL_RTC;
                `PE_REGION_PLIC: sel_d = SEL_PLIC;
                default:         sel_d = SEL_NONE;
            endcase
        end
    end

    assign mem_req_o.en    = (sel_d == SEL_DATA);
    assign mem_req_o.we    = cpu_req_i.we;
    assign mem_req_o.addr  = cpu_req_i.addr[`PE_MEM_AW-1:0];
    assign mem_req_o.wdata = cpu_req_i.wdata;

    assign rtc_en_o  = (sel_d == SEL_RTC);
    assign plic_en_o = (sel_d == SEL_PLIC);

    // Read data returns in the next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q <= SEL_NONE;
        end else begin
            sel_q <= sel_d;
        end
    end

    // Memory data passes through when no peripheral was selected
    always_comb begin
        case (sel_q)
            SEL_RTC:  cpu_rdata_o = rtc_rdata_i;
            SEL_PLIC: cpu_rdata_o = plic_rdata_i;
            default:  cpu_rdata_o = mem_rdata_i;
        endcase
    end

    // A selected peripheral returns known read data
    a_rdata_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (sel_q == SEL_RTC || sel_q == SEL_PLIC) |-> !$isunknown(cpu_rdata_o)
    ) else $error("peripheral read data unknown");

endmodule

`default_nettype wire

// File: design/pe_br_pkg.sv
`default_nettype none

`include "pe_defines.svh"

package pe_br_pkg;

    // Service carried by a broadcast flit
    typedef enum logic [1:0] {
        BR_SVC_MON    = 2'd0,
        BR_SVC_SVC    = 2'd1,
        BR_SVC_CLEAR  = 2'd2,
        BR_SVC_TARGET = 2'd3
    } br_svc_t;

    // Flit as carried by the broadcast router
    typedef struct packed {
        br_svc_t                    service;
        logic [`BR_KSVC_W-1:0]      ksvc;
        logic [`BR_ADDR_W-1:0]      producer;
        logic [`BR_ADDR_W-1:0]      seq_source;
        logic [`BR_ADDR_W-1:0]      seq_target;
        logic [`BR_ID_W-1:0]        id;
        logic [`BR_PAYLOAD_W-1:0]   payload;
    } br_flit_t;

    // Local sender view, source and id are added by the port
    typedef struct packed {
        br_svc_t                    service;
        logic [`BR_KSVC_W-1:0]      ksvc;
        logic [`BR_ADDR_W-1:0]      producer;
        logic [`BR_ADDR_W-1:0]      seq_target;
        logic [`BR_PAYLOAD_W-1:0]   payload;
    } br_out_t;

    // Monitoring channel word
    typedef struct packed {
        logic [`BR_PAYLOAD_W-1:0]   payload;
        logic [`BR_ADDR_W-1:0]      seq_source;
        logic [`BR_ADDR_W-1:0]      producer;
        logic [`BR_MSVC_W-1:0]      msvc;
    } br_mon_t;

    // Service channel word
    typedef struct packed {
        logic [`BR_PAYLOAD_W-1:0]   payload;
        logic [`BR_ADDR_W-1:0]      seq_source;
        logic [`BR_ADDR_W-1:0]      producer;
        logic [`BR_KSVC_W-1:0]      ksvc;
    } br_svc_flit_t;

endpackage

`default_nettype wire

// File: design/pe_bus_pkg.sv
`default_nettype none

`include "pe_defines.svh"

package pe_bus_pkg;

    // One write-mask bit per byte lane
    localparam int PE_NBYTES = `PE_XLEN / 8;

    ////////////////////////////////////////////////////////////////////////////
    // CPU data bus
    ////////////////////////////////////////////////////////////////////////////

    // Request issued by the core, data returns one cycle later
    typedef struct packed {
        logic                   en;
        logic [PE_NBYTES-1:0]   we;
        logic [`PE_XLEN-1:0]    addr;
        logic [`PE_XLEN-1:0]    wdata;
    } cpu_req_t;

    // Request seen by the external data memory
    typedef struct packed {
        logic                   en;
        logic [PE_NBYTES-1:0]   we;
        logic [`PE_MEM_AW-1:0]  addr;
        logic [`PE_XLEN-1:0]    wdata;
    } mem_req_t;

    ////////////////////////////////////////////////////////////////////////////
    // Decoded targets
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_DATA = 2'd1,
        SEL_RTC  = 2'd2,
        SEL_PLIC = 2'd3
    } periph_sel_t;

endpackage

`default_nettype wire

// File: design/pe_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defines.svh"

module pe_periph_top #(
    parameter int unsigned PE_ADDR_X = 0,
    parameter int unsigned PE_ADDR_Y = 0,
    parameter int unsigned N_PE_X    = 2
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // CPU data bus
    input  pe_bus_pkg::cpu_req_t        cpu_req_i,
    output logic [`PE_XLEN-1:0]         cpu_rdata_o,

    // External data memory
    output pe_bus_pkg::mem_req_t        mem_req_o,
    input  wire logic [`PE_XLEN-1:0]    mem_rdata_i,

    // Interrupts and time
    input  wire logic [`PLIC_NSRC-1:0]  irq_src_i,
    output logic                        mti_o,
    output logic                        mei_o,
    output logic [63:0]                 mtime_o,

    // Broadcast network
    input  wire logic                   dlv_req_i,
    input  pe_br_pkg::br_flit_t         dlv_flit_i,
    output logic                        dlv_ack_o,
    output logic                        mon_req_o,
    output pe_br_pkg::br_mon_t          mon_o,
    input  wire logic                   mon_ack_i,
    output logic                        svc_req_o,
    output pe_br_pkg::br_svc_flit_t     svc_o,
    input  wire logic                   svc_ack_i,
    input  wire logic                   snd_req_i,
    input  pe_br_pkg::br_out_t          snd_flit_i,
    output logic                        snd_ack_o,
    output logic                        br_req_o,
    output pe_br_pkg::br_flit_t         br_flit_o,
    input  wire logic                   br_ack_i
);

    logic                   rtc_en;
    logic                   plic_en;
    logic [`PE_XLEN-1:0]    rtc_rdata;
    logic [`PE_XLEN-1:0]    plic_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode and peripherals
    ////////////////////////////////////////////////////////////////////////////

    pe_addr_decode u_addr_decode (
        .clk_i        (clk_i      ),
        .rst_ni       (rst_ni     ),
        .cpu_req_i    (cpu_req_i  ),
        .cpu_rdata_o  (cpu_rdata_o),
        .mem_req_o    (mem_req_o  ),
        .mem_rdata_i  (mem_rdata_i),
        .rtc_en_o     (rtc_en     ),
        .plic_en_o    (plic_en    ),
        .rtc_rdata_i  (rtc_rdata  ),
        .plic_rdata_i (plic_rdata )
    );

    // Peripherals share the bus address and write data
    pe_rtc u_rtc (
        .clk_i   (clk_i    ),
        .rst_ni  (rst_ni   ),
        .en_i    (rtc_en   ),
        .req_i   (cpu_req_i),
        .rdata_o (rtc_rdata),
        .mti_o   (mti_o    ),
        .mtime_o (mtime_o  )
    );

    pe_plic u_plic (
        .clk_i     (clk_i     ),
        .rst_ni    (rst_ni    ),
        .en_i      (plic_en   ),
        .req_i     (cpu_req_i ),
        .rdata_o   (plic_rdata),
        .irq_src_i (irq_src_i ),
        .mei_o     (mei_o     )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Broadcast local port
    ////////////////////////////////////////////////////////////////////////////

    br_local_port #(
        .PE_ADDR_X (PE_ADDR_X),
        .PE_ADDR_Y (PE_ADDR_Y),
        .N_PE_X    (N_PE_X   )
    ) u_br_local_port (
        .clk_i      (clk_i     ),
        .rst_ni     (rst_ni    ),
        .dlv_req_i  (dlv_req_i ),
        .dlv_flit_i (dlv_flit_i),
        .dlv_ack_o  (dlv_ack_o ),
        .mon_req_o  (mon_req_o ),
        .mon_o      (mon_o     ),
        .mon_ack_i  (mon_ack_i ),
        .svc_req_o  (svc_req_o ),
        .svc_o      (svc_o     ),
        .svc_ack_i  (svc_ack_i ),
        .snd_req_i  (snd_req_i ),
        .snd_flit_i (snd_flit_i),
        .snd_ack_o  (snd_ack_o ),
        .br_req_o   (br_req_o  ),
        .br_flit_o  (br_flit_o ),
        .br_ack_i   (br_ack_i  )
    );

endmodule

`default_nettype wire

// File: design/pe_plic.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defines.svh"

module pe_plic (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire logic                   en_i,
    input  pe_bus_pkg::cpu_req_t        req_i,
    output logic [`PE_XLEN-1:0]         rdata_o,

    input  wire logic [`PLIC_NSRC-1:0]  irq_src_i,
    output logic                        mei_o
);

    logic [`PLIC_NSRC-1:0]  pending_q;
    logic [`PLIC_NSRC-1:0]  enable_q;
    logic [`PLIC_NSRC-1:0]  clr;
    logic [`PLIC_NSRC-1:0]  active;
    logic [`PE_XLEN-1:0]    claim_id;
    logic [`PE_XLEN-1:0]    rdata_q;
    logic [3:0]             ofs;
    logic                   wr;

    assign ofs = req_i.addr[3:0];
    assign wr  = en_i && (|req_i.we);

    // Write one to clear
    assign clr = (wr && ofs == `PLIC_OFS_PENDING) ? req_i.wdata[`PLIC_NSRC-1:0] : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            // A source still asserted keeps its bit set
            pending_q <= (pending_q & ~clr) | irq_src_i;
            if (wr && ofs == `PLIC_OFS_ENABLE) begin
                enable_q <= req_i.wdata[`PLIC_NSRC-1:0];
            end
        end
    end

    assign active = pending_q & enable_q;
    assign mei_o  = |active;

    // Lowest index wins, id is index plus one
    always_comb begin
        claim_id = '0;
        for (int i = `PLIC_NSRC - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id = `PE_XLEN'(i + 1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            case (ofs)
                `PLIC_OFS_ENABLE:  rdata_q <= `PE_XLEN'(enable_q);
                `PLIC_OFS_PENDING: rdata_q <= `PE_XLEN'(pending_q);
                `PLIC_OFS_CLAIM:   rdata_q <= claim_id;
                default:           rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/pe_rtc.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defines.svh"

module pe_rtc (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire logic                   en_i,
    input  pe_bus_pkg::cpu_req_t        req_i,
    output logic [`PE_XLEN-1:0]         rdata_o,

    output logic                        mti_o,
    output logic [63:0]                 mtime_o
);

    import pe_bus_pkg::*;

    logic [63:0]            mtime_q;
    logic [63:0]            mtimecmp_q;
    logic [`PE_XLEN-1:0]    rdata_q;
    logic [3:0]             ofs;
    logic                   wr;

    assign ofs = req_i.addr[3:0];
    assign wr  = en_i && (|req_i.we);

    // Free running tick counter, writes to it are ignored
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // Compare register with byte lanes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (wr) begin
            for (int b = 0; b < PE_NBYTES; b++) begin
                if (req_i.we[b] && ofs == `RTC_OFS_CMP_LO) begin
                    mtimecmp_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
                if (req_i.we[b] && ofs == `RTC_OFS_CMP_HI) begin
                    mtimecmp_q[`PE_XLEN + 8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            case (ofs)
                `RTC_OFS_MTIME_LO: rdata_q <= mtime_q[`PE_XLEN-1:0];
                `RTC_OFS_MTIME_HI: rdata_q <= mtime_q[63:`PE_XLEN];
                `RTC_OFS_CMP_LO:   rdata_q <= mtimecmp_q[`PE_XLEN-1:0];
                `RTC_OFS_CMP_HI:   rdata_q <= mtimecmp_q[63:`PE_XLEN];
                default:           rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

    a_mtime_monotonic: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mtime_q >= $past(mtime_q)
    ) else $error("mtime went backwards");

endmodule

`default_nettype wire

// File: dv/pe_periph_patterns.txt
# test op f1 f2 f3 expected, numbers in hex
# wr addr wdata mask mem_en | rd addr mem_rdata - rdata | tick addr | irq sources
# mti/mei - - - level | dlv service ksvc hold is_mon | snd service ksvc target id
1 wr   01000010 cafef00d f 1
1 rd   01000010 12345678 0 12345678
1 wr   08000020 11111111 f 0
1 rd   08000020 a5a5a5a5 0 a5a5a5a5
2 mti  0 0 0 0
2 tick 02000000 0 0 0
2 tick 02000000 0 0 0
2 wr   02000008 00000000 f 0
2 wr   0200000c 00000000 f 0
2 mti  0 0 0 1
2 rd   02000008 0 0 00000000
2 wr   02000008 ffffffff f 0
2 wr   0200000c ffffffff f 0
2 mti  0 0 0 0
2 rd   0200000c 0 0 ffffffff
3 irq  4 0 0 0
3 mei  0 0 0 0
3 rd   04000008 0 0 0
3 wr   04000000 6 f 0
3 mei  0 0 0 1
3 rd   04000008 0 0 3
3 rd   04000004 0 0 4
3 irq  0 0 0 0
3 wr   04000004 4 f 0
3 mei  0 0 0 0
3 rd   04000008 0 0 0
4 dlv  0 2d 3 1
4 dlv  1 5a 1 0
4 dlv  2 07 0 0
4 dlv  3 81 2 0
5 snd  1 10 0007 0
5 snd  0 22 0002 1
5 snd  3 ff 0000 2

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset released on a falling edge, away from the flops
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_pe_periph.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_defines.svh"

module tb_pe_periph;

    import pe_bus_pkg::*;
    import pe_br_pkg::*;

    localparam int unsigned PE_ADDR_X = 1;
    localparam int unsigned PE_ADDR_Y = 1;
    localparam int unsigned N_PE_X    = 2;
    // Position (1,1) in a two-wide mesh
    localparam int          SEQ_ADDR  = 3;
    localparam int          TIMEOUT   = 20;

    logic                       clk;
    logic                       rst_n;
    cpu_req_t                   cpu_req;
    logic [`PE_XLEN-1:0]        cpu_rdata;
    mem_req_t                   mem_req;
    logic [`PE_XLEN-1:0]        mem_rdata;
    logic [`PLIC_NSRC-1:0]      irq_src;
    logic                       mti;
    logic                       mei;
    logic [63:0]                mtime;
    logic                       dlv_req;
    br_flit_t                   dlv_flit;
    logic                       dlv_ack;
    logic                       mon_req;
    br_mon_t                    mon;
    logic                       mon_ack;
    logic                       svc_req;
    br_svc_flit_t               svc;
    logic                       svc_ack;
    logic                       snd_req;
    br_out_t                    snd_flit;
    logic                       snd_ack;
    logic                       br_req;
    br_flit_t                   br_flit;
    logic                       br_ack;

    logic [63:0]                ref_mtime;

    int                         errors;
    int                         checks;
    int                         tests;
    int                         seed;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk  ),
        .rst_no (rst_n)
    );

    pe_periph_top #(
        .PE_ADDR_X (PE_ADDR_X),
        .PE_ADDR_Y (PE_ADDR_Y),
        .N_PE_X    (N_PE_X   )
    ) u_pe_periph_top (
        .clk_i       (clk      ),
        .rst_ni      (rst_n    ),
        .cpu_req_i   (cpu_req  ),
        .cpu_rdata_o (cpu_rdata),
        .mem_req_o   (mem_req  ),
        .mem_rdata_i (mem_rdata),
        .irq_src_i   (irq_src  ),
        .mti_o       (mti      ),
        .mei_o       (mei      ),
        .mtime_o     (mtime    ),
        .dlv_req_i   (dlv_req  ),
        .dlv_flit_i  (dlv_flit ),
        .dlv_ack_o   (dlv_ack  ),
        .mon_req_o   (mon_req  ),
        .mon_o       (mon      ),
        .mon_ack_i   (mon_ack  ),
        .svc_req_o   (svc_req  ),
        .svc_o       (svc      ),
        .svc_ack_i   (svc_ack  ),
        .snd_req_i   (snd_req  ),
        .snd_flit_i  (snd_flit ),
        .snd_ack_o   (snd_ack  ),
        .br_req_o    (br_req   ),
        .br_flit_o   (br_flit  ),
        .br_ack_i    (br_ack   )
    );

    // Expected tick count, one step per clock out of reset
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_mtime <= '0;
        end else begin
            ref_mtime <= ref_mtime + 64'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input int num, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d passed", num);
        end else begin
            $display("test %0d failed with %0d errors", num, errors - errs_before);
        end
    endtask

    // Single-cycle bus write, decode checked while the request is up
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask, input logic exp_en);
        @(posedge clk);
        cpu_req.en    <= 1'b1;
        cpu_req.we    <= mask;
        cpu_req.addr  <= addr;
        cpu_req.wdata <= data;
        @(negedge clk);
        check_value("mem_req_o.en", 64'(mem_req.en), 64'(exp_en));
        if (exp_en) begin
            check_value("mem_req_o.addr", 64'(mem_req.addr), 64'(addr[`PE_MEM_AW-1:0]));
            check_value("mem_req_o.wdata", 64'(mem_req.wdata), 64'(data));
            check_value("mem_req_o.we", 64'(mem_req.we), 64'(mask));
        end
        @(posedge clk);
        cpu_req.en <= 1'b0;
        cpu_req.we <= '0;
    endtask

    // Data is taken exactly one cycle after the request
    task automatic bus_read(input logic [31:0] addr, input logic [31:0] mem_data,
                            output logic [31:0] data);
        @(posedge clk);
        cpu_req.en   <= 1'b1;
        cpu_req.we   <= '0;
        cpu_req.addr <= addr;
        mem_rdata    <= mem_data;
        @(posedge clk);
        cpu_req.en <= 1'b0;
        @(negedge clk);
        data = cpu_rdata;
    endtask

    task automatic deliver_flit(input logic [1:0] svc_code, input logic [7:0] ksvc,
                                input int hold, input logic exp_mon);
        br_flit_t f;
        int       n;
        f.service    = br_svc_t'(svc_code);
        f.ksvc       = ksvc;
        f.producer   = 16'($random(seed));
        f.seq_source = 16'($random(seed));
        f.seq_target = 16'($random(seed));
        f.id         = 5'($random(seed));
        f.payload    = $random(seed);
        @(posedge clk);
        dlv_req  <= 1'b1;
        dlv_flit <= f;
        // Only the other channel acks while the consumer stalls
        mon_ack  <= !exp_mon;
        svc_ack  <= exp_mon;
        // Consumer stalls, nothing may transfer
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("dlv_ack_o", 64'(dlv_ack), 64'(0));
            check_value("mon_req_o", 64'(mon_req), 64'(exp_mon));
            @(posedge clk);
        end
        if (exp_mon) begin
            mon_ack <= 1'b1;
            svc_ack <= 1'b0;
        end else begin
            svc_ack <= 1'b1;
            mon_ack <= 1'b0;
        end
        n = 0;
        @(negedge clk);
        while (dlv_ack !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            errors++;
            $display("delivery ack did not return within %0d cycles", TIMEOUT);
        end
        check_value("mon_req_o", 64'(mon_req), 64'(exp_mon));
        check_value("svc_req_o", 64'(svc_req), 64'(!exp_mon));
        if (exp_mon) begin
            check_value("mon_o.payload", 64'(mon.payload), 64'(f.payload));
            check_value("mon_o.seq_source", 64'(mon.seq_source), 64'(f.seq_source));
            check_value("mon_o.producer", 64'(mon.producer), 64'(f.producer));
            check_value("mon_o.msvc", 64'(mon.msvc), 64'(ksvc[1:0]));
        end else begin
            check_value("svc_o.payload", 64'(svc.payload), 64'(f.payload));
            check_value("svc_o.seq_source", 64'(svc.seq_source), 64'(f.seq_source));
            check_value("svc_o.producer", 64'(svc.producer), 64'(f.producer));
            check_value("svc_o.ksvc", 64'(svc.ksvc), 64'(ksvc));
        end
        @(posedge clk);
        dlv_req <= 1'b0;
        mon_ack <= 1'b0;
        svc_ack <= 1'b0;
    endtask

    task automatic send_flit(input logic [1:0] svc_code, input logic [7:0] ksvc,
                             input logic [15:0] target, input logic [4:0] exp_id);
        br_out_t o;
        int      n;
        o.service    = br_svc_t'(svc_code);
        o.ksvc       = ksvc;
        o.producer   = 16'($random(seed));
        o.seq_target = target;
        o.payload    = $random(seed);
        @(posedge clk);
        snd_req  <= 1'b1;
        snd_flit <= o;
        n = 0;
        @(negedge clk);
        while (br_req !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            errors++;
            $display("send request never reached the router within %0d cycles", TIMEOUT);
        end
        check_value("br_flit_o.service", 64'(br_flit.service), 64'(svc_code));
        check_value("br_flit_o.ksvc", 64'(br_flit.ksvc), 64'(ksvc));
        check_value("br_flit_o.producer", 64'(br_flit.producer), 64'(o.producer));
        check_value("br_flit_o.seq_source", 64'(br_flit.seq_source), 64'(SEQ_ADDR));
        check_value("br_flit_o.seq_target", 64'(br_flit.seq_target), 64'(target));
        check_value("br_flit_o.id", 64'(br_flit.id), 64'(exp_id));
        check_value("br_flit_o.payload", 64'(br_flit.payload), 64'(o.payload));
        @(posedge clk);
        br_ack <= 1'b1;
        @(negedge clk);
        check_value("snd_ack_o", 64'(snd_ack), 64'(1));
        @(posedge clk);
        br_ack  <= 1'b0;
        snd_req <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Pattern sequencer
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          code;
        int          n;
        int          test_no;
        int          cur_test;
        int          test_err;
        string       tok;
        string       op;
        string       rest;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] expv;
        logic [31:0] rdata;
        logic [31:0] last_time;
        logic        have_time;

        cpu_req   <= '0;
        mem_rdata <= '0;
        irq_src   <= '0;
        dlv_req   <= 1'b0;
        dlv_flit  <= '0;
        mon_ack   <= 1'b0;
        svc_ack   <= 1'b0;
        snd_req   <= 1'b0;
        snd_flit  <= '0;
        br_ack    <= 1'b0;
        seed      = 24;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        cur_test  = 0;
        test_err  = 0;
        last_time = '0;
        have_time = 1'b0;

        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n == TIMEOUT) begin
            errors++;
            $display("reset was never released");
        end

        fd = $fopen("dv/pe_periph_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (tok.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                    continue;
                end
                test_no = tok.atoi();
                code = $fscanf(fd, "%s %h %h %h %h", op, f1, f2, f3, expv);
                if (code != 5) begin
                    errors++;
                    $display("malformed pattern line in test %0d", test_no);
                    break;
                end
                if (test_no != cur_test) begin
                    if (cur_test != 0) begin
                        report_test(cur_test, test_err);
                    end
                    cur_test = test_no;
                    test_err = errors;
                    tests++;
                end
                if (op == "wr") begin
                    bus_write(f1, f2, f3[3:0], expv[0]);
                end else if (op == "rd") begin
                    bus_read(f1, f2, rdata);
                    check_value("cpu_rdata_o", 64'(rdata), 64'(expv));
                end else if (op == "tick") begin
                    bus_read(f1, f2, rdata);
                    // Low word was captured in the request cycle, one tick back
                    check_value("cpu_rdata_o", 64'(rdata), 64'(ref_mtime[31:0] - 32'd1));
                    check_value("mtime_o", mtime, ref_mtime);
                    // Time only moves forward
                    if (have_time) begin
                        check_value("mtime_lo_not_older", 64'(rdata >= last_time), 64'(1));
                    end
                    last_time = rdata;
                    have_time = 1'b1;
                end else if (op == "irq") begin
                    @(posedge clk);
                    irq_src <= f1[`PLIC_NSRC-1:0];
                    // Controller latches the source on the next edge
                    @(posedge clk);
                end else if (op == "mti") begin
                    @(negedge clk);
                    check_value("mti_o", 64'(mti), 64'(expv[0]));
                end else if (op == "mei") begin
                    @(negedge clk);
                    check_value("mei_o", 64'(mei), 64'(expv[0]));
                end else if (op == "dlv") begin
                    deliver_flit(f1[1:0], f2[7:0], int'(f3), expv[0]);
                end else if (op == "snd") begin
                    send_flit(f1[1:0], f2[7:0], f3[15:0], expv[4:0]);
                end else begin
                    errors++;
                    $display("unknown operation %s in test %0d", op, test_no);
                end
            end
            $fclose(fd);
        end
        if (cur_test != 0) begin
            report_test(cur_test, test_err);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/pe_defines.svh
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// CPU data bus and external data memory
`define PE_XLEN             32
`define PE_MEM_AW           24

// Region codes, compared with address bits [31:24]
`define PE_REGION_DATA      8'h01
`define PE_REGION_RTC       8'h02
`define PE_REGION_PLIC      8'h04

// RTC register offsets
`define RTC_OFS_MTIME_LO    4'h0
`define RTC_OFS_MTIME_HI    4'h4
`define RTC_OFS_CMP_LO      4'h8
`define RTC_OFS_CMP_HI      4'hC

// Interrupt controller offsets and source count
`define PLIC_OFS_ENABLE     4'h0
`define PLIC_OFS_PENDING    4'h4
`define PLIC_OFS_CLAIM      4'h8
`define PLIC_NSRC           4

// Broadcast network field widths
`define BR_PAYLOAD_W        32
`define BR_ADDR_W           16
`define BR_ID_W             5
`define BR_KSVC_W           8
`define BR_MSVC_W           2

`endif

// File: phivers_pe_periph.f
+incdir+include
design/pe_bus_pkg.sv
design/pe_br_pkg.sv
design/pe_addr_decode.sv
design/pe_rtc.sv
design/pe_plic.sv
design/br_local_port.sv
design/pe_periph_top.sv
dv/tb_clock_gen.sv
dv/tb_pe_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the peripheral testbench with Verilator.
# Run from anywhere; all paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f phivers_pe_periph.f --top-module tb_pe_periph -o sim_pe_periph
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pe_periph > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
